// File: all.f
logic/a53_pkg.sv
logic/a53_regs.sv
logic/a53_prg_map.sv
logic/a53_ppu_map.sv
logic/a53_mapper.sv
testbench/a53_tb.sv

// File: testbench/a53_tb.sv
/* Directed testbench for the Action 53 mapper top level.
   Runs the preset boards and the native register set against a register model. */
`timescale 1ns/1ps
`default_nettype none

module a53_tb;

	import a53_pkg::*;

	localparam int PRG_BITS    = 5;
	localparam int CYCLE_LIMIT = 2000; // Directed run is about 300 cycles

	logic       clk;
	logic       arst_n;
	logic       ce;
	logic       enable;
	mapper_id_t mapper_id;
	logic       mirror_vert;
	logic       chr_is_ram;
	cpu_addr_t  prg_ain;
	bus_data_t  prg_din;
	logic       prg_write;
	ppu_addr_t  chr_ain;
	mem_addr_t  prg_aout;
	logic       prg_allow;
	logic       prg_conflict;
	logic       prg_open_bus;
	mem_addr_t  chr_aout;
	logic       chr_allow;
	logic       vram_ce;
	logic       vram_a10;

	// Register model follows accepted writes and presets
	logic [5:0] m_mode;
	logic [5:0] m_outer;
	logic [3:0] m_inner;
	logic [1:0] m_chr;
	sel_e       m_sel;

	logic [31:0] lfsr_state;
	int cycles;
	int errors;
	int checks;
	int tests;
	int err_mark;
	int chk_mark;

	a53_mapper #(
		.PRG_BANK_BITS (PRG_BITS)
	) dut0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.ce           (ce),
		.enable       (enable),
		.mapper_id    (mapper_id),
		.mirror_vert  (mirror_vert),
		.chr_is_ram   (chr_is_ram),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.prg_write    (prg_write),
		.chr_ain      (chr_ain),
		.prg_aout     (prg_aout),
		.prg_allow    (prg_allow),
		.prg_conflict (prg_conflict),
		.prg_open_bus (prg_open_bus),
		.chr_aout     (chr_aout),
		.chr_allow    (chr_allow),
		.vram_ce      (vram_ce),
		.vram_a10     (vram_a10)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles without reaching the end", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1; one step per bit returned
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// PRG bank rule on the model state
	function automatic mem_addr_t prg_addr_rule(input cpu_addr_t a);
		int n;
		int top;
		int bank;
		n = m_mode[5:4];                          // Inner bits in the bank
		top = (int'(m_outer) >> n) << (n + 1);    // Upper 6-n outer bits in place
		if (!m_mode[3])
			bank = top | ((int'(m_inner) & ((1 << n) - 1)) << 1) | a[14];
		else if ((!m_mode[2] && a[14]) || (m_mode[2] && !a[14]))
			bank = top | (int'(m_inner) & ((1 << (n + 1)) - 1)); // Switching half
		else
			bank = (int'(m_outer) << 1) | a[14];
		bank = bank % (1 << PRG_BITS);            // Only low bank bits reach ROM
		return mem_addr_t'(bank * 16384 + a[13:0]);
	endfunction

	task automatic model_preset(input mapper_id_t id, input logic vert);
		m_mode[5:2] = 4'b0000;
		m_outer = 6'h3F;
		m_inner = 4'h0;
		m_sel = SEL_INNER;
		if (id == MAPPER_NROM || id == MAPPER_UNROM || id == MAPPER_CNROM)
			m_mode[1:0] = vert ? MIR_VERT : MIR_HORZ;
		if (id == MAPPER_UNROM)
			m_mode[5:2] = 4'b1111;
		if (id == MAPPER_CNROM)
			m_sel = SEL_CHR;
		if (id == MAPPER_AXROM) begin
			m_mode[1:0] = 2'b00;
			m_mode[5:2] = 4'b1100;
			m_outer = 6'h00;
		end
	endtask

	task automatic model_write(input cpu_addr_t a, input bus_data_t d);
		if (a[15:12] == 4'h5 && mapper_id == MAPPER_A53) begin
			m_sel = sel_e'({d[7], d[0]});
		end else if (a[15]) begin
			case (m_sel)
				SEL_CHR: begin
					m_chr = d[1:0];
					if (!m_mode[1])
						m_mode[0] = d[4]; // One-screen page
				end
				SEL_INNER: begin
					m_inner = d[3:0];
					if (!m_mode[1])
						m_mode[0] = d[4];
				end
				SEL_MODE:  m_mode = d[5:0];
				default:   m_outer = d[5:0];
			endcase
		end
	endtask

	task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Walks the four nametable quadrants and checks CIRAM A10
	task automatic check_mirror(input string what, input mirror_e mir);
		ppu_addr_t a;
		logic exp;
		int q;
		for (q = 0; q < 4; q++) begin
			@(negedge clk);
			a = {2'b10, q[1:0], 10'(rand_bits(10))};
			chr_ain = a;
			#1;
			case (mir)
				MIR_VERT: exp = a[10];
				MIR_HORZ: exp = a[11];
				default:  exp = mir[0]; // One screen
			endcase
			check_bit(what, vram_a10, exp);
			check_bit("vram_ce", vram_ce, 1'b1);
		end
	endtask

	task automatic bus_write(input cpu_addr_t a, input bus_data_t d, input logic strobe);
		@(negedge clk);
		prg_ain = a;
		prg_din = d;
		prg_write = 1'b1;
		ce = strobe;
		@(negedge clk);
		ce = 1'b0;
		prg_write = 1'b0;
		if (!enable)
			model_preset(mapper_id, mirror_vert); // Preset wins while disabled
		else if (strobe)
			model_write(a, d);
	endtask

	task automatic probe_prg(input cpu_addr_t a);
		@(negedge clk);
		prg_ain = a;
		prg_write = 1'b0;
		ce = 1'b0;
		#1;
		check_addr($sformatf("prg_aout at %h", a), prg_aout, prg_addr_rule(a));
	endtask

	task automatic probe_chr(input ppu_addr_t a);
		@(negedge clk);
		chr_ain = a;
		#1;
		check_addr($sformatf("chr_aout at %h", a), chr_aout, {CHR_BASE, m_chr, a[12:0]});
		check_bit("vram_ce", vram_ce, a[13]); // Pattern table side
	endtask

	// Flags straight from the address and board type
	task automatic probe_flags(input cpu_addr_t a, input logic wr);
		@(negedge clk);
		prg_ain = a;
		prg_write = wr;
		ce = 1'b0; // No strobe so registers stay
		#1;
		check_bit("prg_allow", prg_allow, a[15] & ~wr);
		check_bit("prg_conflict", prg_conflict, a[15] && mapper_id == MAPPER_CNROM);
		check_bit("prg_open_bus", prg_open_bus,
			a[15:13] == 3'b011 && mapper_id == MAPPER_AXROM);
		prg_write = 1'b0;
	endtask

	// Disabled for two cycles to load the preset
	task automatic start_mapper(input mapper_id_t id, input logic vert);
		@(negedge clk);
		enable = 1'b0;
		mapper_id = id;
		mirror_vert = vert;
		repeat (2) @(negedge clk);
		enable = 1'b1;
		model_preset(id, vert);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %-10s %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	task automatic test_reset();
		probe_flags(16'h0000, 1'b0);
		probe_prg({1'b1, 15'(rand_bits(15))});
		check_mirror("reset mirroring", MIR_ONE_LO);
		finish_test("reset");
	endtask

	task automatic test_nrom();
		cpu_addr_t a;
		int i;
		start_mapper(MAPPER_NROM, 1'b1);
		for (i = 0; i < 8; i++) begin
			a = {1'b1, 15'(rand_bits(15))};
			probe_prg(a);
			check_addr("nrom bank", prg_aout, {3'b000, 4'b1111, a[14], a[13:0]});
			probe_flags(a, 1'b0);
			probe_flags(a, 1'b1);
		end
		check_mirror("nrom mirroring", MIR_VERT);
		finish_test("nrom");
	endtask

	task automatic test_unrom();
		cpu_addr_t a;
		int i;
		start_mapper(MAPPER_UNROM, 1'b0);
		for (i = 0; i < 6; i++) begin
			bus_write(16'h8000, 8'(rand_bits(8)), 1'b1);
			probe_prg({2'b10, 14'(rand_bits(14))}); // Switching half
			a = {2'b11, 14'(rand_bits(14))};
			probe_prg(a);
			check_addr("unrom fixed half", prg_aout, {3'b000, 5'b11111, a[13:0]});
		end
		check_mirror("unrom mirroring", MIR_HORZ);
		finish_test("unrom");
	endtask

	task automatic test_a53();
		int i;
		start_mapper(MAPPER_A53, 1'b0);
		for (i = 0; i < 6; i++) begin
			bus_write({4'h5, 12'(rand_bits(12))}, {1'b1, 6'(rand_bits(6)), 1'b0}, 1'b1);
			bus_write(16'h8000, {2'b00, 6'(rand_bits(6))}, 1'b1);
			bus_write(16'h5000, 8'h81, 1'b1); // Outer
			bus_write({1'b1, 15'(rand_bits(15))}, 8'(rand_bits(8)), 1'b1);
			bus_write(16'h5FFF, 8'h01, 1'b1); // Inner
			bus_write(16'hC000, 8'(rand_bits(8)), 1'b1);
			probe_prg({2'b10, 14'(rand_bits(14))});
			probe_prg({2'b11, 14'(rand_bits(14))});
			check_mirror("a53 mirroring", mirror_e'(m_mode[1:0]));
		end
		finish_test("a53");
	endtask

	task automatic test_cnrom();
		int i;
		start_mapper(MAPPER_CNROM, 1'b1);
		for (i = 0; i < 4; i++) begin
			bus_write({1'b1, 15'(rand_bits(15))}, 8'(rand_bits(8)), 1'b1);
			probe_chr({1'b0, 13'(rand_bits(13))});
		end
		for (i = 0; i < 8; i++)
			probe_flags(16'(rand_bits(16)), 1'b0);
		@(negedge clk);
		chr_is_ram = 1'b0;
		#1;
		check_bit("chr_allow", chr_allow, 1'b0);
		@(negedge clk);
		chr_is_ram = 1'b1;
		#1;
		check_bit("chr_allow", chr_allow, 1'b1);
		finish_test("cnrom");
	endtask

	task automatic test_axrom();
		bus_data_t d;
		int i;
		start_mapper(MAPPER_AXROM, 1'b1);
		for (i = 0; i < 4; i++) begin
			d = 8'(rand_bits(8));
			d[4] = i[0]; // Page toggles every write
			bus_write(16'h8000, d, 1'b1);
			check_mirror("axrom page", i[0] ? MIR_ONE_HI : MIR_ONE_LO);
			probe_prg({1'b1, 15'(rand_bits(15))});
		end
		for (i = 0; i < 8; i++)
			probe_flags(i[0] ? {3'b011, 13'(rand_bits(13))} : 16'(rand_bits(16)), 1'b0);
		finish_test("axrom");
	endtask

	task automatic test_gating();
		start_mapper(MAPPER_CNROM, 1'b0);
		probe_chr(14'h0123);
		bus_write(16'h8000, {6'b0, ~m_chr}, 1'b0); // No strobe
		probe_chr(14'h0123);
		@(negedge clk);
		enable = 1'b0;
		bus_write(16'h8000, {6'b0, ~m_chr}, 1'b1); // Disabled
		probe_chr(14'h0123);
		start_mapper(MAPPER_UNROM, 1'b0);
		bus_write(16'h8000, 8'h0B, 1'b0);
		probe_prg(16'h8000);
		@(negedge clk);
		prg_ain = 16'h8000;
		prg_din = 8'h0B;
		prg_write = 1'b1;
		ce = 1'b1;
		#1;
		check_addr("prg_aout before edge", prg_aout, prg_addr_rule(16'h8000));
		@(negedge clk);
		ce = 1'b0;
		prg_write = 1'b0;
		model_write(16'h8000, 8'h0B);
		#1;
		check_addr("prg_aout after edge", prg_aout, prg_addr_rule(16'h8000));
		finish_test("gating");
	endtask

	initial begin
		arst_n = 1'b0;
		ce = 1'b0;
		enable = 1'b0;
		mapper_id = MAPPER_A53;
		mirror_vert = 1'b0;
		chr_is_ram = 1'b1;
		prg_ain = '0;
		prg_din = '0;
		prg_write = 1'b0;
		chr_ain = '0;
		lfsr_state = 32'hfca66208;
		cycles = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		err_mark = 0;
		chk_mark = 0;
		m_mode = 6'h00; // Reset state of the mapper
		m_outer = 6'h3F;
		m_inner = 4'h0;
		m_chr = 2'b00;
		m_sel = SEL_INNER;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;

		test_reset();
		test_nrom();
		test_unrom();
		test_a53();
		test_cnrom();
		test_axrom();
		test_gating();

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/a53_mapper.sv
/* Top level of the Action 53 cartridge mapper for the NES core.
   Connects the register file to the CPU and PPU address maps. */
`timescale 1ns/1ps
`default_nettype none

module a53_mapper #(
	parameter int PRG_BANK_BITS = 5 // ROM bank bits, 5 gives 512K PRG
) (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     ce,          // M2 strobe
	input  wire                     enable,      // Low holds the preset
	input  wire a53_pkg::mapper_id_t mapper_id,
	input  wire                     mirror_vert, // Header mirroring bit
	input  wire                     chr_is_ram,
	input  wire a53_pkg::cpu_addr_t  prg_ain,
	input  wire a53_pkg::bus_data_t  prg_din,
	input  wire                     prg_write,
	input  wire a53_pkg::ppu_addr_t  chr_ain,
	output wire a53_pkg::mem_addr_t  prg_aout,
	output wire                     prg_allow,
	output wire                     prg_conflict,
	output wire                     prg_open_bus,
	output wire a53_pkg::mem_addr_t  chr_aout,
	output wire                     chr_allow,
	output wire                     vram_ce,
	output wire                     vram_a10
);

	import a53_pkg::*;

	// Register state shared by both maps
	wire [5:0] mode;
	wire [5:0] outer;
	wire [3:0] inner;
	wire [1:0] chr_bank;

	a53_regs regs0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.ce          (ce),
		.enable      (enable),
		.mapper_id   (mapper_id),
		.mirror_vert (mirror_vert),
		.prg_ain     (prg_ain),
		.prg_din     (prg_din),
		.prg_write   (prg_write),
		.mode        (mode),
		.outer       (outer),
		.inner       (inner),
		.chr_bank    (chr_bank)
	);

	a53_prg_map #(
		.PRG_BANK_BITS (PRG_BANK_BITS)
	) prg_map0 (
		.mapper_id    (mapper_id),
		.prg_ain      (prg_ain),
		.prg_write    (prg_write),
		.mode         (mode),
		.outer        (outer),
		.inner        (inner),
		.prg_aout     (prg_aout),
		.prg_allow    (prg_allow),
		.prg_conflict (prg_conflict),
		.prg_open_bus (prg_open_bus)
	);

	a53_ppu_map ppu_map0 (
		.chr_ain    (chr_ain),
		.chr_is_ram (chr_is_ram),
		.mirror     (mirror_e'(mode[1:0])), // Mirroring field of mode
		.chr_bank   (chr_bank),
		.chr_aout   (chr_aout),
		.chr_allow  (chr_allow),
		.vram_ce    (vram_ce),
		.vram_a10   (vram_a10)
	);

endmodule

`default_nettype wire

// File: logic/a53_ppu_map.sv
/* PPU-side map for the Action 53 mapper: 8K CHR RAM bank select and
   nametable A10 from the mirroring code. */
`timescale 1ns/1ps
`default_nettype none

module a53_ppu_map (
	input  wire a53_pkg::ppu_addr_t chr_ain,
	input  wire                    chr_is_ram,
	input  wire a53_pkg::mirror_e   mirror,    // From mode[1:0]
	input  wire [1:0]              chr_bank,
	output a53_pkg::mem_addr_t     chr_aout,
	output logic                   chr_allow, // CHR writes reach memory
	output logic                   vram_ce,   // Route to internal 2K VRAM
	output logic                   vram_a10   // CIRAM A10
);

	import a53_pkg::*;

	// Pattern tables, 8K bank in the CHR window
	assign chr_aout = {CHR_BASE, chr_bank, chr_ain[12:0]};

	assign chr_allow = chr_is_ram;
	assign vram_ce   = chr_ain[13]; // $2000-$3FFF nametables

	always_comb begin
		case (mirror)
			MIR_ONE_LO,
			MIR_ONE_HI: vram_a10 = mirror[0];   // Page from code
			MIR_VERT:   vram_a10 = chr_ain[10]; // $2000/$2800 share
			MIR_HORZ:   vram_a10 = chr_ain[11]; // $2000/$2400 share
			default:    vram_a10 = chr_ain[10];
		endcase
	end

endmodule

`default_nettype wire

// File: logic/a53_prg_map.sv
/* CPU-side bank translation for the Action 53 mapper.
   Combines outer and inner banks per the mode register and raises the PRG flags. */
`timescale 1ns/1ps
`default_nettype none

module a53_prg_map #(
	parameter int PRG_BANK_BITS = 5 // Low bank bits that reach the ROM, 1 to 7
) (
	input  wire a53_pkg::mapper_id_t mapper_id,
	input  wire a53_pkg::cpu_addr_t  prg_ain,
	input  wire                     prg_write,
	input  wire [5:0]               mode,
	input  wire [5:0]               outer,
	input  wire [3:0]               inner,
	output a53_pkg::mem_addr_t      prg_aout,
	output logic                    prg_allow,    // ROM read window
	output logic                    prg_conflict, // CNROM bus conflict
	output logic                    prg_open_bus  // AxROM has no WRAM
);

	import a53_pkg::*;

	// Zero fill above the bank bits
	localparam int PAD_BITS = $bits(mem_addr_t) - PRG_BANK_BITS - 14;

	logic [1:0] outer_size; // Inner bits that replace outer bits
	logic       unrom_sw;   // Access hits the switching half
	prg_bank_t  nrom_bank;  // 32K switch
	prg_bank_t  unrom_bank; // 16K switch
	prg_bank_t  bank;

	assign outer_size = mode[MODE_SIZE_HI:MODE_SIZE_LO];

	// 10 switches $C000, 11 switches $8000
	assign unrom_sw = mode[MODE_UNROM] & (mode[MODE_FIX_HI] ^ prg_ain[14]);

	always_comb begin
		case (outer_size)
			2'd0: begin // 32K outer bank
				nrom_bank  = {outer[5:0], prg_ain[14]};
				unrom_bank = {outer[5:0], inner[0]};
			end
			2'd1: begin // 64K
				nrom_bank  = {outer[5:1], inner[0], prg_ain[14]};
				unrom_bank = {outer[5:1], inner[1:0]};
			end
			2'd2: begin // 128K
				nrom_bank  = {outer[5:2], inner[1:0], prg_ain[14]};
				unrom_bank = {outer[5:2], inner[2:0]};
			end
			default: begin // 256K
				nrom_bank  = {outer[5:3], inner[2:0], prg_ain[14]};
				unrom_bank = {outer[5:3], inner[3:0]};
			end
		endcase

		if (!mode[MODE_UNROM])
			bank = nrom_bank;
		else if (unrom_sw)
			bank = unrom_bank;
		else
			bank = {outer, prg_ain[14]}; // Fixed 16K half
	end

	// Only the low bank bits reach the ROM
	assign prg_aout = {{PAD_BITS{1'b0}}, bank[PRG_BANK_BITS-1:0], prg_ain[13:0]};

	assign prg_allow    = prg_ain[15] & ~prg_write;
	assign prg_conflict = prg_ain[15] & (mapper_id == MAPPER_CNROM);
	assign prg_open_bus = (prg_ain[15:13] == WRAM_PAGE) & (mapper_id == MAPPER_AXROM);

endmodule

`default_nettype wire

// File: logic/a53_regs.sv
/* Control block of the Action 53 mapper: register file, CPU write decode
   and the presets that emulate simpler boards while the mapper is held off. */
`timescale 1ns/1ps
`default_nettype none

module a53_regs (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     ce,          // One-cycle CPU strobe
	input  wire                     enable,      // Low loads the preset
	input  wire a53_pkg::mapper_id_t mapper_id,
	input  wire                     mirror_vert, // Header mirroring, 1 is vertical
	input  wire a53_pkg::cpu_addr_t  prg_ain,
	input  wire a53_pkg::bus_data_t  prg_din,
	input  wire                     prg_write,
	output logic [5:0]              mode,        // Size, layout, mirroring
	output logic [5:0]              outer,       // Outer PRG bank
	output logic [3:0]              inner,       // Inner PRG bank
	output logic [1:0]              chr_bank     // 8K CHR bank
);

	import a53_pkg::*;

	sel_e sel; // Which register $8000 writes land in

	logic wr_en;       // Accepted CPU write this cycle
	logic sel_wr;      // Write to the select register
	logic bank_wr;     // Write to the selected register
	logic is_a53;      // Native mapper, $5000 reachable
	logic fixed_mir;   // Boards with soldered mirroring
	logic mode0_next;  // One-screen page after CHR or inner write
	mirror_e hdr_mir;  // Mirroring taken from the header

	// Write decode
	assign wr_en   = enable & ce & prg_write;
	assign is_a53  = (mapper_id == MAPPER_A53);
	assign sel_wr  = wr_en & (prg_ain[15:12] == SEL_PAGE) & is_a53;
	assign bank_wr = wr_en & prg_ain[15]; // $8000-$FFFF

	// Only one-screen modes let the data bus pick the page
	assign mode0_next = mode[MODE_MIR_HI] ? mode[MODE_MIR_LO] : prg_din[4];

	// NROM, UNROM and CNROM take mirroring from the header
	assign fixed_mir = (mapper_id == MAPPER_NROM) ||
		(mapper_id == MAPPER_UNROM) ||
		(mapper_id == MAPPER_CNROM);
	assign hdr_mir = mirror_vert ? MIR_VERT : MIR_HORZ;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode     <= '0;         // 32K NROM, one screen lower
			outer    <= OUTER_LAST;
			inner    <= '0;
			chr_bank <= '0;
			sel      <= SEL_INNER;
		end else if (!enable) begin
			// Base preset maps the last 32K as NROM
			mode[5:2] <= 4'b0000;
			outer     <= OUTER_LAST;
			inner     <= '0;
			sel       <= SEL_INNER;

			if (fixed_mir)
				mode[1:0] <= hdr_mir;

			// UNROM switches $8000, $C000 fixed to top of outer bank
			if (mapper_id == MAPPER_UNROM)
				mode[5:2] <= LAYOUT_UNROM;

			// CNROM writes go to the CHR bank
			if (mapper_id == MAPPER_CNROM)
				sel <= SEL_CHR;

			// AxROM switches 32K through inner and takes the page from bit 4
			if (mapper_id == MAPPER_AXROM) begin
				mode[1:0] <= MIR_ONE_LO;
				mode[5:2] <= LAYOUT_AXROM;
				outer     <= '0;
			end
		end else begin
			if (sel_wr)
				sel <= sel_e'({prg_din[7], prg_din[0]});

			if (bank_wr) begin
				case (sel)
					SEL_CHR: begin
						chr_bank <= prg_din[1:0];
						mode[0]  <= mode0_next;
					end
					SEL_INNER: begin
						inner   <= prg_din[3:0];
						mode[0] <= mode0_next;
					end
					SEL_MODE: begin
						mode <= prg_din[5:0];
					end
					SEL_OUTER: begin
						outer <= prg_din[5:0];
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/a53_pkg.sv
/* Shared types and codes for the Action 53 multi-discrete mapper.
   Imported by the control module, both address maps and the testbench. */
`default_nettype none

package a53_pkg;

	// Bus widths seen by the mapper
	typedef logic [15:0] cpu_addr_t; // CPU address bus
	typedef logic [13:0] ppu_addr_t; // PPU address bus
	typedef logic [21:0] mem_addr_t; // Cartridge memory address
	typedef logic [7:0]  bus_data_t; // CPU data byte
	typedef logic [7:0]  mapper_id_t; // iNES mapper number

	// Full PRG bank number, 16K granularity
	typedef logic [6:0] prg_bank_t;

	// Mapper IDs that this core can stand in for
	localparam mapper_id_t MAPPER_NROM  = 8'd0;
	localparam mapper_id_t MAPPER_UNROM = 8'd2;
	localparam mapper_id_t MAPPER_CNROM = 8'd3;
	localparam mapper_id_t MAPPER_AXROM = 8'd7;
	localparam mapper_id_t MAPPER_A53   = 8'd28; // Native multi-discrete mode

	// Nametable mirroring, held in mode[1:0]
	// One-screen codes keep the page in bit 0
	typedef enum logic [1:0] {
		MIR_ONE_LO = 2'd0, // One screen, lower page
		MIR_ONE_HI = 2'd1, // One screen, upper page
		MIR_VERT   = 2'd2, // Vertical, A10 from PPU A10
		MIR_HORZ   = 2'd3  // Horizontal, A10 from PPU A11
	} mirror_e;

	// Register select, loaded through $5000
	typedef enum logic [1:0] {
		SEL_CHR   = 2'd0, // CHR RAM bank
		SEL_INNER = 2'd1, // Inner PRG bank
		SEL_MODE  = 2'd2, // Mode register
		SEL_OUTER = 2'd3  // Outer PRG bank
	} sel_e;

	// Mode register field positions
	localparam int MODE_SIZE_HI   = 5; // Outer bank size, upper bit
	localparam int MODE_SIZE_LO   = 4; // Outer bank size, lower bit
	localparam int MODE_UNROM     = 3; // UNROM layout when set
	localparam int MODE_FIX_HI    = 2; // Fixed half select in UNROM layout
	localparam int MODE_MIR_HI    = 1; // Mirroring upper bit
	localparam int MODE_MIR_LO    = 0; // Mirroring lower bit, one-screen page

	// Preset values loaded while the mapper is held disabled
	localparam logic [5:0] OUTER_LAST    = 6'h3F; // Last 32K of the ROM
	localparam logic [3:0] LAYOUT_UNROM  = 4'b1111; // 256K, UNROM, fixed top half
	localparam logic [3:0] LAYOUT_AXROM  = 4'b1100; // 256K, NROM-style 32K switch

	// Upper CHR address prefix, places CHR in the RAM window
	localparam logic [6:0] CHR_BASE = 7'b1000000;

	// CPU address windows
	localparam logic [3:0] SEL_PAGE  = 4'h5;   // $5000-$5FFF select register
	localparam logic [2:0] WRAM_PAGE = 3'b011; // $6000-$7FFF

endpackage

`default_nettype wire
